// ==== hdl/uart_config.svh ====
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Character and baud generator widths
`define UART_DATA_W 8
`define UART_NCO_W 16

// FIFO depths in characters
`define UART_TX_DEPTH 8
`define UART_RX_DEPTH 4

`endif

// ==== hdl/uart_line_pkg.sv ====
`include "uart_config.svh"

package uart_line_pkg;

  // One character on the serial line
  typedef logic [`UART_DATA_W-1:0] uart_byte_t;

  // Frame format, shared by transmitter and receiver
  typedef struct packed {
    logic parity_en;
    logic parity_odd;
  } uart_frame_cfg_t;

  // Per-character report from the receiver, valid for one cycle
  typedef struct packed {
    logic       valid;
    uart_byte_t data;
    logic       frame_err;
    logic       parity_err;
  } uart_rx_result_t;

endpackage

// ==== hdl/uart_host_pkg.sv ====
`include "uart_config.svh"

package uart_host_pkg;

  // Static control, held while traffic flows
  typedef struct packed {
    logic                         tx_en;
    logic                         rx_en;
    logic                         nf_en;
    uart_line_pkg::uart_frame_cfg_t frame;
    logic [`UART_NCO_W-1:0]       nco;
  } uart_ctrl_t;

  // Sticky receive errors, cleared by the host
  typedef struct packed {
    logic frame_err;
    logic parity_err;
    logic overflow;
  } uart_err_t;

  typedef struct packed {
    logic      tx_full;
    logic      tx_empty;
    logic      tx_idle;
    logic      rx_full;
    logic      rx_empty;
    logic      rx_idle;
    uart_err_t err;
  } uart_status_t;

endpackage

// ==== hdl/uart_baud_gen.sv ====
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_baud_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   en_i,
  input  logic [`UART_NCO_W-1:0] nco_i,
  output logic                   tick_x16_o
);

  // Extra top bit holds the carry out of the accumulator
  logic [`UART_NCO_W:0] acc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (en_i) begin
      acc_q <= {1'b0, acc_q[`UART_NCO_W-1:0]} + {1'b0, nco_i};
    end else begin
      // Restart the phase so no stale carry is seen
      acc_q <= '0;
    end
  end

  assign tick_x16_o = acc_q[`UART_NCO_W];

endmodule

// ==== hdl/uart_fifo.sv ====
`timescale 1ns/1ps

module uart_fifo #(
  parameter int Depth = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clr_i,
  input  logic                          push_i,
  input  uart_line_pkg::uart_byte_t     data_i,
  output logic                          full_o,
  input  logic                          pop_i,
  output uart_line_pkg::uart_byte_t     data_o,
  output logic                          empty_o,
  output logic [$clog2(Depth+1)-1:0]    depth_o
);

  import uart_line_pkg::*;

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  uart_byte_t            mem_q [Depth];
  logic [PtrW-1:0]       wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]       cnt_q;
  logic                  do_push, do_pop;

  // Push into a full FIFO and pop from an empty one are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CntW'(do_push) - CntW'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign full_o  = (cnt_q == CntW'(Depth));
  assign empty_o = (cnt_q == '0);
  assign depth_o = cnt_q;

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_tx (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           en_i,
  input  logic                           tick_x16_i,
  input  uart_line_pkg::uart_frame_cfg_t cfg_i,
  input  logic                           fifo_empty_i,
  input  uart_line_pkg::uart_byte_t      fifo_data_i,
  output logic                           fifo_pop_o,
  output logic                           idle_o,
  output logic                           tx_o
);

  // Start, data, parity slot and stop
  localparam int FrameW = `UART_DATA_W + 3;

  logic [FrameW-1:0] sreg_q, frame;
  logic [3:0]        bit_cnt_q, div_q;
  logic              tx_q, parity, bit_tick;

  assign parity = (^fifo_data_i) ^ cfg_i.parity_odd;
  assign frame  = cfg_i.parity_en ? {1'b1, parity, fifo_data_i, 1'b0} :
                                    {2'b11, fifo_data_i, 1'b0};

  assign idle_o     = (bit_cnt_q == '0);
  assign fifo_pop_o = en_i & idle_o & ~fifo_empty_i;
  assign bit_tick   = en_i & ~idle_o & tick_x16_i & (div_q == 4'hf);

  //////////////////////////////////////////////////
  // Bit timing
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt_q <= '0;
      div_q     <= '0;
      tx_q      <= 1'b1;
    end else if (!en_i) begin
      bit_cnt_q <= '0;
      div_q     <= '0;
      tx_q      <= 1'b1;
    end else if (fifo_pop_o) begin
      // One extra shift so the stop bit lasts a full bit period
      bit_cnt_q <= cfg_i.parity_en ? 4'd12 : 4'd11;
      // Start bit goes out on the very next tick
      div_q     <= 4'hf;
    end else if (tick_x16_i && !idle_o) begin
      div_q <= div_q + 1'b1;
      if (bit_tick) begin
        tx_q      <= sreg_q[0];
        bit_cnt_q <= bit_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_pop_o) begin
      sreg_q <= frame;
    end else if (bit_tick) begin
      sreg_q <= {1'b1, sreg_q[FrameW-1:1]};
    end
  end

  assign tx_o = tx_q;

endmodule

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_rx (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           en_i,
  input  logic                           nf_en_i,
  input  logic                           tick_x16_i,
  input  uart_line_pkg::uart_frame_cfg_t cfg_i,
  input  logic                           rx_i,
  output uart_line_pkg::uart_rx_result_t result_o,
  output logic                           idle_o
);

  import uart_line_pkg::*;

  // Bit index of the parity slot, right after the data bits
  localparam logic [3:0] ParIdx = 4'(`UART_DATA_W + 1);

  logic            sync_q1, sync_q2, filt_q1, filt_q2;
  logic            rx_maj, rx_bit;
  logic            busy_q;
  logic [3:0]      div_q, bit_cnt_q, last_idx;
  logic            sample, done;
  uart_byte_t      data_q;
  logic            par_q;
  uart_rx_result_t result_q;

  //////////////////////////////////////////////////
  // Synchronizer and noise filter
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q1 <= 1'b1;
      sync_q2 <= 1'b1;
      filt_q1 <= 1'b1;
      filt_q2 <= 1'b1;
    end else begin
      sync_q1 <= rx_i;
      sync_q2 <= sync_q1;
      filt_q1 <= sync_q2;
      filt_q2 <= filt_q1;
    end
  end

  // Two out of three consecutive samples win
  assign rx_maj = (sync_q2 & filt_q1) | (sync_q2 & filt_q2) | (filt_q1 & filt_q2);
  assign rx_bit = nf_en_i ? rx_maj : sync_q2;

  //////////////////////////////////////////////////
  // Deserializer
  //////////////////////////////////////////////////

  assign last_idx = cfg_i.parity_en ? ParIdx + 4'd1 : ParIdx;
  assign sample   = busy_q & tick_x16_i & (div_q == 4'd7);
  assign done     = sample & (bit_cnt_q == last_idx);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      div_q     <= '0;
      bit_cnt_q <= '0;
    end else if (!en_i) begin
      busy_q <= 1'b0;
    end else if (!busy_q) begin
      // Low line on a tick marks a candidate start bit
      if (tick_x16_i && !rx_bit) begin
        busy_q    <= 1'b1;
        div_q     <= '0;
        bit_cnt_q <= '0;
      end
    end else if (tick_x16_i) begin
      div_q <= div_q + 1'b1;
      if (sample) begin
        if ((bit_cnt_q == '0) && rx_bit) begin
          // Start bit gone at mid-bit, treat as noise
          busy_q <= 1'b0;
        end else if (done) begin
          busy_q <= 1'b0;
        end else begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sample && (bit_cnt_q != '0) && (bit_cnt_q < ParIdx)) begin
      data_q <= {rx_bit, data_q[`UART_DATA_W-1:1]};
    end
    if (sample && cfg_i.parity_en && (bit_cnt_q == ParIdx)) begin
      par_q <= rx_bit;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_q <= '0;
    end else begin
      result_q.valid      <= done & en_i;
      result_q.data       <= data_q;
      result_q.frame_err  <= ~rx_bit;
      result_q.parity_err <= cfg_i.parity_en &
                             (par_q != ((^data_q) ^ cfg_i.parity_odd));
    end
  end

  assign result_o = result_q;
  assign idle_o   = ~busy_q;

endmodule

// ==== hdl/uart_host_port.sv ====
`timescale 1ns/1ps

module uart_host_port (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           wr_req_i,
  input  uart_line_pkg::uart_byte_t      wr_data_i,
  output logic                           wr_ack_o,
  input  logic                           rd_req_i,
  output uart_line_pkg::uart_byte_t      rd_data_o,
  output logic                           rd_ack_o,
  input  logic                           err_clr_i,
  input  uart_line_pkg::uart_rx_result_t rx_result_i,
  input  logic                           tx_full_i,
  output logic                           tx_push_o,
  output uart_line_pkg::uart_byte_t      tx_data_o,
  input  logic                           rx_empty_i,
  input  logic                           rx_full_i,
  output logic                           rx_push_o,
  output logic                           rx_pop_o,
  input  uart_line_pkg::uart_byte_t      rx_data_i,
  output uart_host_pkg::uart_err_t       err_o
);

  import uart_line_pkg::*;
  import uart_host_pkg::*;

  typedef enum logic {
    PortIdle,
    PortAck
  } port_state_e;

  port_state_e wr_state_q, rd_state_q;
  uart_byte_t  rd_data_q;
  uart_err_t   err_q;
  logic        rx_good;

  //////////////////////////////////////////////////
  // Four-phase write and read ports
  //////////////////////////////////////////////////

  assign tx_push_o = (wr_state_q == PortIdle) & wr_req_i & ~tx_full_i;
  assign tx_data_o = wr_data_i;
  assign rx_pop_o  = (rd_state_q == PortIdle) & rd_req_i & ~rx_empty_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_state_q <= PortIdle;
      rd_state_q <= PortIdle;
    end else begin
      if (tx_push_o) begin
        wr_state_q <= PortAck;
      end else if (!wr_req_i) begin
        wr_state_q <= PortIdle;
      end
      if (rx_pop_o) begin
        rd_state_q <= PortAck;
      end else if (!rd_req_i) begin
        rd_state_q <= PortIdle;
      end
    end
  end

  // Head byte captured with the pop, held until the next read
  always_ff @(posedge clk_i) begin
    if (rx_pop_o) begin
      rd_data_q <= rx_data_i;
    end
  end

  assign wr_ack_o  = (wr_state_q == PortAck);
  assign rd_ack_o  = (rd_state_q == PortAck);
  assign rd_data_o = rd_data_q;

  //////////////////////////////////////////////////
  // Receive filtering and sticky errors
  //////////////////////////////////////////////////

  assign rx_good   = rx_result_i.valid & ~rx_result_i.frame_err & ~rx_result_i.parity_err;
  assign rx_push_o = rx_good & ~rx_full_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= '0;
    end else if (err_clr_i) begin
      err_q <= '0;
    end else begin
      err_q.frame_err  <= err_q.frame_err | (rx_result_i.valid & rx_result_i.frame_err);
      err_q.parity_err <= err_q.parity_err | (rx_result_i.valid & rx_result_i.parity_err);
      // Good byte with nowhere to go
      err_q.overflow   <= err_q.overflow | (rx_good & rx_full_i);
    end
  end

  assign err_o = err_q;

endmodule

// ==== hdl/uart_top.sv ====
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  uart_host_pkg::uart_ctrl_t ctrl_i,
  input  logic                      wr_req_i,
  input  uart_line_pkg::uart_byte_t wr_data_i,
  output logic                      wr_ack_o,
  input  logic                      rd_req_i,
  output uart_line_pkg::uart_byte_t rd_data_o,
  output logic                      rd_ack_o,
  input  logic                      err_clr_i,
  output uart_host_pkg::uart_status_t status_o,
  output logic                      tx_o,
  input  logic                      rx_i
);

  import uart_line_pkg::*;
  import uart_host_pkg::*;

  logic            tick_x16;
  logic            tx_push, tx_pop, tx_full, tx_empty, tx_idle;
  logic            rx_push, rx_pop, rx_full, rx_empty, rx_idle;
  uart_byte_t      tx_wdata, tx_rdata, rx_rdata;
  uart_rx_result_t rx_result;
  uart_err_t       err;

  uart_baud_gen u_baud_gen (
    .clk_i,
    .rst_ni,
    .en_i       (ctrl_i.tx_en | ctrl_i.rx_en),
    .nco_i      (ctrl_i.nco),
    .tick_x16_o (tick_x16)
  );

  //////////////////////////////////////////////////
  // Transmit path
  //////////////////////////////////////////////////

  uart_fifo #(
    .Depth (`UART_TX_DEPTH)
  ) u_tx_fifo (
    .clk_i,
    .rst_ni,
    .clr_i   (1'b0),
    .push_i  (tx_push),
    .data_i  (tx_wdata),
    .full_o  (tx_full),
    .pop_i   (tx_pop),
    .data_o  (tx_rdata),
    .empty_o (tx_empty),
    .depth_o ()
  );

  uart_tx u_tx (
    .clk_i,
    .rst_ni,
    .en_i         (ctrl_i.tx_en),
    .tick_x16_i   (tick_x16),
    .cfg_i        (ctrl_i.frame),
    .fifo_empty_i (tx_empty),
    .fifo_data_i  (tx_rdata),
    .fifo_pop_o   (tx_pop),
    .idle_o       (tx_idle),
    .tx_o
  );

  //////////////////////////////////////////////////
  // Receive path
  //////////////////////////////////////////////////

  uart_rx u_rx (
    .clk_i,
    .rst_ni,
    .en_i       (ctrl_i.rx_en),
    .nf_en_i    (ctrl_i.nf_en),
    .tick_x16_i (tick_x16),
    .cfg_i      (ctrl_i.frame),
    .rx_i,
    .result_o   (rx_result),
    .idle_o     (rx_idle)
  );

  uart_fifo #(
    .Depth (`UART_RX_DEPTH)
  ) u_rx_fifo (
    .clk_i,
    .rst_ni,
    .clr_i   (1'b0),
    .push_i  (rx_push),
    .data_i  (rx_result.data),
    .full_o  (rx_full),
    .pop_i   (rx_pop),
    .data_o  (rx_rdata),
    .empty_o (rx_empty),
    .depth_o ()
  );

  uart_host_port u_host_port (
    .clk_i,
    .rst_ni,
    .wr_req_i,
    .wr_data_i,
    .wr_ack_o,
    .rd_req_i,
    .rd_data_o,
    .rd_ack_o,
    .err_clr_i,
    .rx_result_i (rx_result),
    .tx_full_i   (tx_full),
    .tx_push_o   (tx_push),
    .tx_data_o   (tx_wdata),
    .rx_empty_i  (rx_empty),
    .rx_full_i   (rx_full),
    .rx_push_o   (rx_push),
    .rx_pop_o    (rx_pop),
    .rx_data_i   (rx_rdata),
    .err_o       (err)
  );

  assign status_o.tx_full  = tx_full;
  assign status_o.tx_empty = tx_empty;
  assign status_o.tx_idle  = tx_idle;
  assign status_o.rx_full  = rx_full;
  assign status_o.rx_empty = rx_empty;
  assign status_o.rx_idle  = rx_idle;
  assign status_o.err      = err;

endmodule

// ==== dv/uart_clk_gen.sv ====
`timescale 1ns/1ps

module uart_clk_gen #(
  parameter int PeriodNs    = 40,
  parameter int ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset released just after a rising edge, away from the sampling point
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

// ==== dv/uart_tb.sv ====
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_tb;

  import uart_line_pkg::*;
  import uart_host_pkg::*;

  localparam int Nco        = 16384;
  // One tick per accumulator carry, sixteen ticks per bit
  localparam int TickCycles = 65536 / Nco;
  localparam int BitCycles  = 16 * TickCycles;
  localparam int WaitCycles = 20 * BitCycles;

  logic         clk, rst_n;
  uart_ctrl_t   ctrl;
  logic         wr_req, wr_ack, rd_req, rd_ack, err_clr;
  uart_byte_t   wr_data, rd_data;
  uart_status_t status;
  logic         tx, rx, rx_drv;
  // High ties the receive line back to the transmitter
  logic         loop_en;

  assign rx = loop_en ? tx : rx_drv;

  uart_clk_gen #(
    .PeriodNs    (40),
    .ResetCycles (4)
  ) u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  uart_top u_uart_top (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .ctrl_i    (ctrl),
    .wr_req_i  (wr_req),
    .wr_data_i (wr_data),
    .wr_ack_o  (wr_ack),
    .rd_req_i  (rd_req),
    .rd_data_o (rd_data),
    .rd_ack_o  (rd_ack),
    .err_clr_i (err_clr),
    .status_o  (status),
    .tx_o      (tx),
    .rx_i      (rx)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic expect_eq(string test, string what, logic [31:0] exp, logic [31:0] act);
    assert (act === exp) else
      stop_on_error($sformatf("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                              test, what, exp, act));
  endtask

  // Inputs change and outputs are sampled 2 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  function automatic logic parity_of(uart_byte_t data, logic odd);
    return (^data) ^ odd;
  endfunction

  task automatic configure(logic tx_en, logic rx_en, logic nf_en, logic par_en,
                           logic par_odd);
    ctrl.tx_en            = tx_en;
    ctrl.rx_en            = rx_en;
    ctrl.nf_en            = nf_en;
    ctrl.frame.parity_en  = par_en;
    ctrl.frame.parity_odd = par_odd;
    ctrl.nco              = `UART_NCO_W'(Nco);
  endtask

  task automatic wait_wr_ack(string test, logic level);
    int cnt;
    cnt = 0;
    while (wr_ack !== level) begin
      if (cnt == WaitCycles)
        stop_on_error($sformatf("[%s] write ack never went to %0b", test, level));
      step();
      cnt++;
    end
  endtask

  task automatic wait_rd_ack(string test, logic level);
    int cnt;
    cnt = 0;
    while (rd_ack !== level) begin
      if (cnt == WaitCycles)
        stop_on_error($sformatf("[%s] read ack never went to %0b", test, level));
      step();
      cnt++;
    end
  endtask

  task automatic wait_tx_done(string test);
    int cnt;
    cnt = 0;
    while (!(status.tx_idle === 1'b1 && status.tx_empty === 1'b1)) begin
      if (cnt == WaitCycles)
        stop_on_error($sformatf("[%s] transmitter never went idle", test));
      step();
      cnt++;
    end
  endtask

  task automatic write_byte(string test, uart_byte_t data);
    wr_data = data;
    wr_req  = 1'b1;
    wait_wr_ack(test, 1'b1);
    wr_req  = 1'b0;
    wait_wr_ack(test, 1'b0);
  endtask

  task automatic read_byte(string test, output uart_byte_t data);
    rd_req = 1'b1;
    wait_rd_ack(test, 1'b1);
    data   = rd_data;
    rd_req = 1'b0;
    wait_rd_ack(test, 1'b0);
  endtask

  // Drives one frame on rx
  // An optional one-cycle glitch sits at the centre of bit glitch_idx
  task automatic send_frame(uart_byte_t data, logic par_en, logic par_bit,
                            logic stop_bit, int glitch_idx);
    logic [11:0] bits;
    int          nbits;
    bits    = '1;
    bits[0] = 1'b0;
    bits[8:1] = data;
    if (par_en) begin
      bits[9]  = par_bit;
      bits[10] = stop_bit;
      nbits    = 11;
    end else begin
      bits[9] = stop_bit;
      nbits   = 10;
    end
    for (int i = 0; i < nbits; i++) begin
      for (int c = 0; c < BitCycles; c++) begin
        rx_drv = (i == glitch_idx && c == BitCycles / 2) ? ~bits[i] : bits[i];
        step();
      end
    end
    // Idle line long enough for the receiver to settle
    rx_drv = 1'b1;
    repeat (2 * BitCycles) step();
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic check_reset_state();
    uart_status_t exp;
    exp          = '0;
    exp.tx_empty = 1'b1;
    exp.tx_idle  = 1'b1;
    exp.rx_empty = 1'b1;
    exp.rx_idle  = 1'b1;
    expect_eq("reset_state", "tx_o", 1, tx);
    expect_eq("reset_state", "wr_ack", 0, wr_ack);
    expect_eq("reset_state", "rd_ack", 0, rd_ack);
    expect_eq("reset_state", "status", exp, status);
  endtask

  task automatic check_tx_framing();
    uart_byte_t data;
    int         cnt;
    loop_en = 1'b0;
    configure(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    data = uart_byte_t'($urandom());
    // Byte waits in the FIFO so the start edge can be caught cleanly
    write_byte("tx_framing", data);
    configure(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    cnt = 0;
    while (tx !== 1'b0) begin
      if (cnt == WaitCycles)
        stop_on_error("[tx_framing] no start bit appeared on tx_o");
      step();
      cnt++;
    end
    repeat (BitCycles / 2) step();
    expect_eq("tx_framing", "start bit", 0, tx);
    for (int i = 0; i < `UART_DATA_W; i++) begin
      repeat (BitCycles) step();
      expect_eq("tx_framing", $sformatf("data bit %0d", i), data[i], tx);
    end
    repeat (BitCycles) step();
    expect_eq("tx_framing", "stop bit", 1, tx);
    wait_tx_done("tx_framing");
  endtask

  task automatic run_round_trip();
    uart_byte_t sent [4];
    uart_byte_t got;
    configure(1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
    loop_en = 1'b1;
    step();
    for (int i = 0; i < 4; i++) begin
      sent[i] = uart_byte_t'($urandom());
      write_byte("round_trip", sent[i]);
    end
    for (int i = 0; i < 4; i++) begin
      read_byte("round_trip", got);
      expect_eq("round_trip", $sformatf("byte %0d", i), sent[i], got);
    end
    expect_eq("round_trip", "error flags", 0, status.err);
    wait_tx_done("round_trip");
  endtask

  task automatic check_rx_errors();
    uart_byte_t data;
    uart_byte_t got;
    loop_en = 1'b0;
    rx_drv  = 1'b1;
    configure(1'b0, 1'b1, 1'b1, 1'b1, 1'b1);
    repeat (BitCycles) step();

    data = uart_byte_t'($urandom());
    send_frame(data, 1'b1, ~parity_of(data, 1'b1), 1'b1, -1);
    expect_eq("rx_errors", "parity_err", 1, status.err.parity_err);
    expect_eq("rx_errors", "frame_err after bad parity", 0, status.err.frame_err);
    expect_eq("rx_errors", "rx_empty after bad parity", 1, status.rx_empty);

    data = uart_byte_t'($urandom());
    send_frame(data, 1'b1, parity_of(data, 1'b1), 1'b0, -1);
    expect_eq("rx_errors", "frame_err", 1, status.err.frame_err);
    expect_eq("rx_errors", "rx_empty after bad stop", 1, status.rx_empty);

    err_clr = 1'b1;
    step();
    expect_eq("rx_errors", "flags after clear", 0, status.err);
    err_clr = 1'b0;

    // Glitch lands in the middle of data bit 3
    data = uart_byte_t'($urandom());
    send_frame(data, 1'b1, parity_of(data, 1'b1), 1'b1, 4);
    read_byte("rx_errors", got);
    expect_eq("rx_errors", "glitched byte", data, got);
    expect_eq("rx_errors", "flags after glitch", 0, status.err);
  endtask

  task automatic check_backpressure();
    uart_byte_t sent [`UART_RX_DEPTH+1];
    uart_byte_t got;
    loop_en = 1'b0;
    rx_drv  = 1'b1;
    configure(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
    for (int i = 0; i < `UART_TX_DEPTH; i++) begin
      write_byte("backpressure", uart_byte_t'($urandom()));
    end
    expect_eq("backpressure", "tx_full", 1, status.tx_full);

    wr_data = uart_byte_t'($urandom());
    wr_req  = 1'b1;
    for (int c = 0; c < 2 * BitCycles; c++) begin
      step();
      expect_eq("backpressure", "wr_ack while full", 0, wr_ack);
    end
    configure(1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
    wait_wr_ack("backpressure", 1'b1);
    wr_req = 1'b0;
    wait_wr_ack("backpressure", 1'b0);

    ///////////////////////////////////////////////
    // Receive FIFO overflow
    for (int i = 0; i <= `UART_RX_DEPTH; i++) begin
      sent[i] = uart_byte_t'($urandom());
      send_frame(sent[i], 1'b0, 1'b0, 1'b1, -1);
    end
    expect_eq("backpressure", "overflow", 1, status.err.overflow);
    expect_eq("backpressure", "rx_full", 1, status.rx_full);
    for (int i = 0; i < `UART_RX_DEPTH; i++) begin
      read_byte("backpressure", got);
      expect_eq("backpressure", $sformatf("rx byte %0d", i), sent[i], got);
    end
    expect_eq("backpressure", "rx_empty after reads", 1, status.rx_empty);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int cnt;
    void'($urandom(32'h9f2c));
    ctrl    = '0;
    wr_req  = 1'b0;
    wr_data = '0;
    rd_req  = 1'b0;
    err_clr = 1'b0;
    rx_drv  = 1'b1;
    loop_en = 1'b0;

    cnt = 0;
    while (rst_n !== 1'b1) begin
      if (cnt == WaitCycles)
        stop_on_error("Reset was never released");
      step();
      cnt++;
    end
    step();

    check_reset_state();
    check_tx_framing();
    run_round_trip();
    check_rx_errors();
    check_backpressure();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/uart_line_pkg.sv
hdl/uart_host_pkg.sv
hdl/uart_baud_gen.sv
hdl/uart_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_host_port.sv
hdl/uart_top.sv
dv/uart_clk_gen.sv
dv/uart_tb.sv

// ==== Bender.yml ====
package:
  name: uart

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/uart_line_pkg.sv
      - hdl/uart_host_pkg.sv
      - hdl/uart_baud_gen.sv
      - hdl/uart_fifo.sv
      - hdl/uart_tx.sv
      - hdl/uart_rx.sv
      - hdl/uart_host_port.sv
      - hdl/uart_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/uart_clk_gen.sv
      - dv/uart_tb.sv
